/* rtl/lr35902_defines.svh */
`ifndef LR35902_DEFINES_SVH
`define LR35902_DEFINES_SVH

// flag bit positions inside flags_t
`define LR_FLAG_Z 3 // zero
`define LR_FLAG_N 2 // subtract
`define LR_FLAG_H 1 // half carry
`define LR_FLAG_C 0 // carry

// clocks in one machine cycle
`define LR_CYCLES_PER_MCYCLE 3'd4

// first opcode fetch address
`define LR_RESET_PC 16'h0000

`endif

/* rtl/lr35902_pkg.sv */
`default_nettype none

package lr35902_pkg;

	typedef logic [7:0]  byte_t;    // data, register or opcode
	typedef logic [15:0] word_t;    // address or pc
	typedef logic [3:0]  flags_t;   // Z N H C, high to low
	typedef logic [2:0]  reg_sel_t; // B C D E H L (HL)/d8 A
	typedef logic [1:0]  mcycle_t;  // clock within machine cycle

	// kind of the current machine cycle
	typedef enum logic [2:0] {
		ST_IFETCH,          // opcode fetch
		ST_IMML_FETCH,      // immediate low byte
		ST_IMMH_FETCH,      // immediate high byte
		ST_INDIRECT_FETCH,  // read at H:L
		ST_INDIRECT_STORE,  // write at H:L
		ST_JUMP             // pc load, no bus access
	} mstate_e;

	// accumulator ops, opcode bits 5..3
	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_ADC,
		ALU_SUB,
		ALU_SBC,
		ALU_AND,
		ALU_XOR,
		ALU_OR,
		ALU_CP
	} alu_op_e;

endpackage

`default_nettype wire

/* rtl/lr35902_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lr35902_defines.svh"

module lr35902_alu (
	input  lr35902_pkg::byte_t  op,
	input  lr35902_pkg::byte_t  a,
	input  lr35902_pkg::byte_t  arg,
	input  lr35902_pkg::byte_t  argi,
	input  logic                carry_in,
	output lr35902_pkg::byte_t  alu_result,
	output lr35902_pkg::byte_t  incdec_result,
	output lr35902_pkg::flags_t alu_flags,
	output lr35902_pkg::flags_t incdec_flags
);
	import lr35902_pkg::*;

	alu_op_e    alu_op;
	logic       cin;     // carry into ADC/SBC only
	logic [8:0] full;    // bit 8 is carry or borrow
	logic [4:0] low;     // nibble sum, bit 4 is half carry
	logic [4:0] low_i;   // same for inc/dec

	assign alu_op = alu_op_e'(op[5:3]);
	assign cin = (alu_op == ALU_ADC || alu_op == ALU_SBC) ? carry_in : 1'b0;

	always_comb begin
		full = '0;
		low = '0;
		alu_result = '0;
		alu_flags = '0;
		case (alu_op)
			ALU_ADD, ALU_ADC: begin
				full = {1'b0, a} + {1'b0, arg} + 9'(cin);
				low = {1'b0, a[3:0]} + {1'b0, arg[3:0]} + 5'(cin);
				alu_result = full[7:0];
				alu_flags[`LR_FLAG_H] = low[4];        // carry out of bit 3
				alu_flags[`LR_FLAG_C] = full[8];
			end
			ALU_SUB, ALU_SBC, ALU_CP: begin
				full = {1'b0, a} - {1'b0, arg} - 9'(cin);
				low = {1'b0, a[3:0]} - {1'b0, arg[3:0]} - 5'(cin);
				alu_result = full[7:0];                // CP result only feeds flags
				alu_flags[`LR_FLAG_N] = 1'b1;
				alu_flags[`LR_FLAG_H] = low[4];        // borrow into bit 4
				alu_flags[`LR_FLAG_C] = full[8];       // borrow out of bit 7
			end
			ALU_AND: begin
				alu_result = a & arg;
				alu_flags[`LR_FLAG_H] = 1'b1;          // AND always sets H
			end
			ALU_XOR: alu_result = a ^ arg;
			ALU_OR:  alu_result = a | arg;
		endcase
		alu_flags[`LR_FLAG_Z] = (alu_result == 8'h00);
	end

	// inc/dec unit, bit 0 of the opcode picks DEC
	always_comb begin
		if (op[0]) begin
			incdec_result = argi - 8'd1;
			low_i = {1'b0, argi[3:0]} - 5'd1;        // borrow when nibble was 0
		end else begin
			incdec_result = argi + 8'd1;
			low_i = {1'b0, argi[3:0]} + 5'd1;        // carry when nibble was F
		end
		incdec_flags[`LR_FLAG_Z] = (incdec_result == 8'h00);
		incdec_flags[`LR_FLAG_N] = op[0];
		incdec_flags[`LR_FLAG_H] = low_i[4];
		incdec_flags[`LR_FLAG_C] = carry_in;         // C untouched by inc/dec
	end

endmodule

`default_nettype wire

/* rtl/lr35902_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

module lr35902_regfile (
	input  logic                  clk,
	input  lr35902_pkg::reg_sel_t src_sel,
	input  lr35902_pkg::reg_sel_t dst_sel,
	input  logic                  reg_we,
	input  lr35902_pkg::byte_t    reg_wdata,
	input  logic                  flags_we,
	input  lr35902_pkg::flags_t   flags_wdata,
	output lr35902_pkg::byte_t    src_val,
	output lr35902_pkg::byte_t    dst_val,
	output lr35902_pkg::byte_t    a_val,
	output lr35902_pkg::byte_t    h_val,
	output lr35902_pkg::byte_t    l_val,
	output lr35902_pkg::flags_t   f_val
);
	import lr35902_pkg::*;

	localparam reg_sel_t SEL_H   = 3'd4;
	localparam reg_sel_t SEL_L   = 3'd5;
	localparam reg_sel_t SEL_MEM = 3'd6; // (HL) or d8, no storage
	localparam reg_sel_t SEL_A   = 3'd7;

	byte_t  regs [8]; // indexed as in the opcode
	flags_t flags;    // Z N H C

	always_ff @(posedge clk) begin
		if (reg_we && dst_sel != SEL_MEM)
			regs[dst_sel] <= reg_wdata;
		if (flags_we)
			flags <= flags_wdata;
	end

	// source port, opcode bits 2..0
	always_comb begin
		if (src_sel == SEL_MEM)
			src_val = 'x;            // control substitutes fetched byte
		else
			src_val = regs[src_sel];
	end

	// destination port, opcode bits 5..3 or A
	always_comb begin
		if (dst_sel == SEL_MEM)
			dst_val = 'x;
		else
			dst_val = regs[dst_sel];
	end

	// fixed taps for accumulator and address pair
	assign a_val = regs[SEL_A];
	assign h_val = regs[SEL_H];
	assign l_val = regs[SEL_L];
	assign f_val = flags;

endmodule

`default_nettype wire

/* rtl/lr35902_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lr35902_defines.svh"

module lr35902_control (
	input  logic                  clk,
	input  logic                  reset,
	input  lr35902_pkg::byte_t    din,
	input  lr35902_pkg::byte_t    src_val,
	input  lr35902_pkg::byte_t    dst_val,
	input  lr35902_pkg::byte_t    a_val,
	input  lr35902_pkg::byte_t    h_val,
	input  lr35902_pkg::byte_t    l_val,
	input  lr35902_pkg::flags_t   f_val,
	input  lr35902_pkg::byte_t    alu_result,
	input  lr35902_pkg::byte_t    incdec_result,
	input  lr35902_pkg::flags_t   alu_flags,
	input  lr35902_pkg::flags_t   incdec_flags,
	output lr35902_pkg::word_t    adr,
	output lr35902_pkg::byte_t    dout,
	output logic                  read,
	output logic                  write,
	output lr35902_pkg::word_t    pc,
	output lr35902_pkg::reg_sel_t src_sel,
	output lr35902_pkg::reg_sel_t dst_sel,
	output logic                  reg_we,
	output lr35902_pkg::byte_t    reg_wdata,
	output logic                  flags_we,
	output lr35902_pkg::flags_t   flags_wdata,
	output lr35902_pkg::byte_t    op,
	output lr35902_pkg::byte_t    arg,
	output lr35902_pkg::byte_t    argi
);
	import lr35902_pkg::*;

	localparam mcycle_t  LAST_CYCLE = mcycle_t'(`LR_CYCLES_PER_MCYCLE - 1);
	localparam reg_sel_t SEL_MEM    = 3'd6;
	localparam reg_sel_t SEL_A      = 3'd7;

	mstate_e state;       // current machine cycle kind
	mstate_e state_next;  // kind of the following one
	mcycle_t cycle;       // clock index 0..3
	logic    run;         // low for one clock after reset
	logic    halted;      // set by HALT, only reset clears
	logic    active;
	logic    last;        // final clock of machine cycle
	logic    bus_window;  // clocks 0 and 1
	logic    pc_step;
	logic    cond_met;    // Z or C matches opcode bit 3
	logic    do_store;
	logic    do_halt;
	byte_t   din_q;       // bus byte sampled end of clock 1
	byte_t   imml;        // immediate low or indirect data
	byte_t   immh;
	word_t   pc_inc;
	word_t   pc_rel;      // pc plus signed offset
	word_t   jump_target;
	word_t   adr_next;

	assign active = run && !halted;
	assign last = active && (cycle == LAST_CYCLE);
	assign bus_window = active && (cycle == 2'd0 || cycle == 2'd1);

	// bus strobes, read never overlaps write
	assign read = bus_window && state != ST_INDIRECT_STORE && state != ST_JUMP;
	assign write = bus_window && state == ST_INDIRECT_STORE;

	// pc bumps once per fetch from the pc
	assign pc_step = active && cycle == 2'd1
		&& (state == ST_IFETCH || state == ST_IMML_FETCH || state == ST_IMMH_FETCH);

	assign pc_inc = pc + 16'd1;
	assign pc_rel = pc + {{8{imml[7]}}, imml};            // JR e8 sign extend
	assign jump_target = (op[7:6] == 2'b00) ? pc_rel : {immh, imml};
	assign cond_met = f_val[op[4] ? `LR_FLAG_C : `LR_FLAG_Z] == op[3];

	// register file selects, ALU ops always target A
	assign src_sel = reg_sel_t'(op[2:0]);
	assign dst_sel = op[7] ? SEL_A : reg_sel_t'(op[5:3]);

	// index 6 means the fetched byte
	assign arg = (src_sel == SEL_MEM) ? imml : src_val;
	assign argi = (dst_sel == SEL_MEM) ? imml : dst_val;

	// decode at the last clock of each machine cycle
	always_comb begin
		state_next = ST_IFETCH;
		reg_we = 1'b0;
		reg_wdata = arg;
		flags_we = 1'b0;
		flags_wdata = alu_flags;
		do_store = 1'b0;
		do_halt = 1'b0;
		if (last) begin
			casez (op)
				8'h76: do_halt = 1'b1;                       // HALT
				8'b00???110: begin                           // LD r,d8
					if (state == ST_IFETCH)
						state_next = ST_IMML_FETCH;
					else
						reg_we = 1'b1;
				end
				8'b00???10?: begin                           // INC r / DEC r
					reg_we = 1'b1;
					reg_wdata = incdec_result;
					flags_we = 1'b1;
					flags_wdata = incdec_flags;
				end
				8'b01??????: begin                           // LD r,r' and (HL) forms
					if (state == ST_IFETCH && src_sel == SEL_MEM) begin
						state_next = ST_INDIRECT_FETCH;
					end else if (op[5:3] == SEL_MEM) begin
						if (state != ST_INDIRECT_STORE) begin
							do_store = 1'b1;                 // latch dout from arg
							state_next = ST_INDIRECT_STORE;
						end
					end else begin
						reg_we = 1'b1;
					end
				end
				8'b10??????, 8'b11???110: begin              // ALU r, (HL), d8
					if (state == ST_IFETCH && src_sel == SEL_MEM) begin
						state_next = op[6] ? ST_IMML_FETCH : ST_INDIRECT_FETCH;
					end else begin
						reg_we = 1'b1;
						// CP writes A back unchanged
						reg_wdata = (alu_op_e'(op[5:3]) == ALU_CP) ? a_val : alu_result;
						flags_we = 1'b1;
					end
				end
				8'hc3, 8'b110??010: begin                    // JP a16, JP cc,a16
					case (state)
						ST_IFETCH:     state_next = ST_IMML_FETCH;
						ST_IMML_FETCH: state_next = ST_IMMH_FETCH;
						ST_IMMH_FETCH: begin
							if (op[0] || cond_met)
								state_next = ST_JUMP;
						end
						default: ;                           // ST_JUMP loads pc
					endcase
				end
				8'h18, 8'b001??000: begin                    // JR e8, JR cc,e8
					case (state)
						ST_IFETCH: state_next = ST_IMML_FETCH;
						ST_IMML_FETCH: begin
							if (!op[5] || cond_met)
								state_next = ST_JUMP;
						end
						default: ;
					endcase
				end
				default: ;                                   // NOP and unsupported
			endcase
		end
	end

	// address for the next machine cycle
	always_comb begin
		if (state_next == ST_INDIRECT_FETCH || state_next == ST_INDIRECT_STORE)
			adr_next = {h_val, l_val};
		else if (state == ST_JUMP)
			adr_next = jump_target;
		else
			adr_next = pc;                                   // already past the last fetch
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= ST_IFETCH;
			cycle <= '0;
			pc <= `LR_RESET_PC;
			adr <= `LR_RESET_PC;
			run <= 1'b0;
			halted <= 1'b0;
		end else begin
			run <= 1'b1;                                     // start after one idle clock
			if (active) begin
				cycle <= last ? '0 : cycle + 2'd1;
				if (pc_step)
					pc <= pc_inc;
				if (last) begin
					state <= state_next;
					adr <= adr_next;
					halted <= do_halt;
					if (state == ST_JUMP)
						pc <= jump_target;
				end
			end
		end
	end

	// data latches
	always_ff @(posedge clk) begin
		if (read && cycle == 2'd1)
			din_q <= din;
		if (active && cycle == 2'd2) begin
			case (state)
				ST_IFETCH:                        op <= din_q;
				ST_IMML_FETCH, ST_INDIRECT_FETCH: imml <= din_q;
				ST_IMMH_FETCH:                    immh <= din_q;
				default: ;
			endcase
		end
		if (do_store)
			dout <= arg;                                     // held through the store cycle
	end

endmodule

`default_nettype wire

/* rtl/lr35902_core.sv */
`timescale 1ns/1ns
`default_nettype none

`include "lr35902_defines.svh"

module lr35902_core (
	input  logic                clk,
	input  logic                reset,
	input  lr35902_pkg::byte_t  din,
	output lr35902_pkg::word_t  adr,
	output lr35902_pkg::byte_t  dout,
	output logic                read,
	output logic                write,
	output lr35902_pkg::word_t  pc,
	output lr35902_pkg::flags_t f
);
	import lr35902_pkg::*;

	reg_sel_t src_sel;
	reg_sel_t dst_sel;
	logic     reg_we;
	byte_t    reg_wdata;
	logic     flags_we;
	flags_t   flags_wdata;
	byte_t    src_val;
	byte_t    dst_val;
	byte_t    a_val;
	byte_t    h_val;
	byte_t    l_val;
	byte_t    op;          // latched opcode
	byte_t    arg;         // ALU operand after (HL)/d8 substitution
	byte_t    argi;        // inc/dec operand
	byte_t    alu_result;
	byte_t    incdec_result;
	flags_t   alu_flags;
	flags_t   incdec_flags;

	lr35902_control u_control (
		.clk(clk), .reset(reset), .din(din),
		.src_val(src_val), .dst_val(dst_val), .a_val(a_val),
		.h_val(h_val), .l_val(l_val), .f_val(f),
		.alu_result(alu_result), .incdec_result(incdec_result),
		.alu_flags(alu_flags), .incdec_flags(incdec_flags),
		.adr(adr), .dout(dout), .read(read), .write(write), .pc(pc),
		.src_sel(src_sel), .dst_sel(dst_sel),
		.reg_we(reg_we), .reg_wdata(reg_wdata),
		.flags_we(flags_we), .flags_wdata(flags_wdata),
		.op(op), .arg(arg), .argi(argi)
	);

	lr35902_regfile u_regfile (
		.clk(clk), .src_sel(src_sel), .dst_sel(dst_sel),
		.reg_we(reg_we), .reg_wdata(reg_wdata),
		.flags_we(flags_we), .flags_wdata(flags_wdata),
		.src_val(src_val), .dst_val(dst_val), .a_val(a_val),
		.h_val(h_val), .l_val(l_val), .f_val(f)
	);

	lr35902_alu u_alu (
		.op(op), .a(a_val), .arg(arg), .argi(argi),
		.carry_in(f[`LR_FLAG_C]),                  // ADC/SBC and inc/dec pass-through
		.alu_result(alu_result), .incdec_result(incdec_result),
		.alu_flags(alu_flags), .incdec_flags(incdec_flags)
	);

endmodule

`default_nettype wire

/* test/lr35902_assertions.sv */
`timescale 1ns/1ns
`default_nettype none

module lr35902_assertions (
	input logic                clk,
	input logic                reset,
	input logic                read,
	input logic                write,
	input lr35902_pkg::word_t  adr
);
	import lr35902_pkg::*;

	// one strobe at a time
	property no_overlap;
		@(posedge clk) disable iff (reset) !(read && write);
	endproperty

	// address held across the whole strobe window
	property adr_stable;
		@(posedge clk) disable iff (reset)
			((read || write) && $past(read || write)) |-> $stable(adr);
	endproperty

	// bus idle right after reset
	property idle_after_reset;
		@(posedge clk) $past(reset) |-> (!read && !write);
	endproperty

	assert property (no_overlap) else $error("read and write high together");
	assert property (adr_stable) else $error("adr changed during a bus access");
	assert property (idle_after_reset) else $error("bus active in the cycle after reset");

endmodule

bind lr35902_core lr35902_assertions u_assertions (
	.clk(clk), .reset(reset), .read(read), .write(write), .adr(adr)
);

`default_nettype wire

/* test/lr35902_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module lr35902_tb;
	import lr35902_pkg::*;

	localparam word_t HL_ADR  = 16'h8010; // H:L set by every program
	localparam word_t HL2_ADR = 16'h8020; // after LD L,20 in the (HL) load test
	localparam int    TIMEOUT = 2000;     // clocks per wait loop

	// row kinds
	localparam logic [2:0] K_ALU  = 3'd0;
	localparam logic [2:0] K_IDC  = 3'd1;
	localparam logic [2:0] K_LDRR = 3'd2;
	localparam logic [2:0] K_LDHL = 3'd3;
	localparam logic [2:0] K_JP   = 3'd4;
	localparam logic [2:0] K_JR   = 3'd5;
	localparam logic [2:0] K_JRB  = 3'd6;  // JR backward

	typedef struct packed {
		logic [2:0] kind;
		logic [1:0] form;     // 0 register, 1 d8, 2 (HL)
		byte_t      opc;      // register-form opcode
		byte_t      a;
		byte_t      b;
		byte_t      sa;       // flag setup: LD A,sa then CP sb
		byte_t      sb;
		logic       rnd;      // random a/b, expected from model
		byte_t      exp_byte;
		flags_t     exp_f;
		word_t      exp_pc;   // 0 means end of program
	} row_t;

	logic   clk;
	logic   reset;
	byte_t  din;
	word_t  adr;
	byte_t  dout;
	logic   read;
	logic   write;
	word_t  pc;
	flags_t f;

	byte_t  mem [65536];
	word_t  cap_adr [$];      // one entry per store
	byte_t  cap_dat [$];
	logic   write_q = 1'b0;
	row_t   table_q [$];
	word_t  wp;               // program write pointer
	int     errors = 0;
	int     checks = 0;
	int unsigned seed_val;

	lr35902_core uut (
		.clk(clk), .reset(reset), .din(din),
		.adr(adr), .dout(dout), .read(read), .write(write),
		.pc(pc), .f(f)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	always @(negedge clk)
		din <= mem[adr];      // async memory, settled well before capture

	always @(posedge clk) begin
		if (write)
			mem[adr] <= dout;
		if (write && !write_q) begin   // log once per store cycle
			cap_adr.push_back(adr);
			cap_dat.push_back(dout);
		end
		write_q <= write;
	end

	// {flags, result} from the flag rules
	function automatic logic [11:0] alu_model(input logic [2:0] opk, input byte_t a,
			input byte_t b, input logic c);
		int     ia;
		int     ib;
		int     cc;
		int     s;
		byte_t  r;
		flags_t fl;
		ia = a;
		ib = b;
		cc = (opk == 3'd1 || opk == 3'd3) ? c : 0;  // ADC and SBC only
		fl = 4'b0000;
		case (opk)
			3'd0, 3'd1: begin
				s = ia + ib + cc;
				r = s[7:0];
				fl[1] = ((ia % 16) + (ib % 16) + cc) > 15;
				fl[0] = s > 255;
			end
			3'd4: begin
				r = a & b;
				fl[1] = 1'b1;
			end
			3'd5: r = a ^ b;
			3'd6: r = a | b;
			default: begin                           // SUB SBC CP
				s = ia - ib - cc;
				r = s[7:0];
				fl[2] = 1'b1;
				fl[1] = (ia % 16) < ((ib % 16) + cc);
				fl[0] = ia < (ib + cc);
			end
		endcase
		fl[3] = (r == 8'h00);
		return {fl, r};
	endfunction

	task automatic add_row(input logic [2:0] kind, input logic [1:0] form, input byte_t opc,
			input byte_t a, input byte_t b, input byte_t sa, input byte_t sb, input logic rnd,
			input byte_t exp_byte, input flags_t exp_f, input word_t exp_pc);
		row_t r;
		r = {kind, form, opc, a, b, sa, sb, rnd, exp_byte, exp_f, exp_pc};
		table_q.push_back(r);
	endtask

	task automatic put(input byte_t v);
		mem[wp] = v;
		wp = wp + 16'd1;
	endtask

	task automatic build_program(input row_t r, output word_t end_adr);
		byte_t reg_ld;
		wp = 16'h0000;
		put(8'h26);                            // LD H,80
		put(HL_ADR[15:8]);
		put(8'h2e);                            // LD L,10
		put(HL_ADR[7:0]);
		put(8'h3e);                            // flags from CP
		put(r.sa);
		put(8'hfe);
		put(r.sb);
		case (r.kind)
			K_ALU: begin
				put(8'h3e);                    // LD A,a
				put(r.a);
				put(8'h06);                    // LD B,b
				put(r.b);
				if (r.form == 2'd1) begin
					put(r.opc | 8'h46);        // ALU d8
					put(r.b);
				end else if (r.form == 2'd2) begin
					put(r.opc | 8'h06);        // ALU (HL)
					mem[HL_ADR] = r.b;
				end else begin
					put(r.opc);
				end
				put(8'h77);
			end
			K_IDC: begin
				reg_ld = 8'h06 | {2'b00, r.opc[5:3], 3'b000};
				put(reg_ld);
				put(r.a);
				put(r.opc);
				put(8'h70 | {5'b0, r.opc[5:3]});  // LD (HL),r
			end
			K_LDRR: begin
				put(8'h0e);                    // LD C,d8
				put(r.a);
				put(8'h51);                    // LD D,C
				put(8'h5a);                    // LD E,D
				put(8'h73);                    // LD (HL),E
			end
			K_LDHL: begin
				mem[HL_ADR] = r.a;
				put(8'h7e);                    // LD A,(HL)
				put(8'h2e);
				put(HL2_ADR[7:0]);
				put(8'h77);
			end
			default: begin                     // branches
				if (r.kind == K_JRB) begin
					put(8'hc3);
					put(8'h30);
					put(8'h00);
					wp = 16'h0030;
					put(r.opc);
					put(8'hee);                // back to 0020
				end else if (r.kind == K_JR) begin
					put(r.opc);
					put(8'h16);                // 000a + 16
				end else begin
					put(r.opc);
					put(8'h20);
					put(8'h00);
				end
				put(8'h3e);                    // not-taken marker
				put(8'h11);
				put(8'h77);
				put(8'h76);
				wp = 16'h0020;
				put(8'h3e);                    // taken marker
				put(8'h22);
				put(8'h77);
			end
		endcase
		put(8'h76);                            // HALT
		end_adr = wp;
	endtask

	task automatic check_byte(input string name, input byte_t got, input byte_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_flags(input string name, input flags_t got, input flags_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic wait_store(output logic ok);
		int n;
		n = 0;
		while (cap_adr.size() == 0 && n < TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		ok = (cap_adr.size() != 0);
	endtask

	// halted once the bus has been quiet longer than any jump cycle gap
	task automatic wait_halt(output logic ok);
		int n;
		int quiet;
		n = 0;
		quiet = 0;
		while (quiet < 12 && n < TIMEOUT) begin
			@(negedge clk);
			quiet = (read || write) ? 0 : quiet + 1;
			n++;
		end
		ok = (quiet >= 12);
	endtask

	task automatic run_row(input row_t r, input int idx);
		logic   ok;
		int     err_start;
		int     i;
		logic [11:0] m;
		flags_t setup_f;
		word_t  end_adr;
		word_t  hold_pc;
		logic   moved;
		err_start = errors;
		if (r.rnd) begin
			r.a = byte_t'($urandom);
			r.b = byte_t'($urandom);
			setup_f = alu_model(3'd7, r.sa, r.sb, 1'b0) >> 8;
			m = alu_model(r.opc[5:3], r.a, r.b, setup_f[0]);
			r.exp_byte = (r.opc[5:3] == 3'd7) ? r.a : m[7:0];  // CP keeps A
			r.exp_f = m[11:8];
		end
		@(negedge clk);
		reset = 1'b1;
		for (i = 0; i < 65536; i++)
			mem[i] = byte_t'(i[7:0] ^ i[15:8] ^ 8'h96);    // fill from both address bytes
		build_program(r, end_adr);
		repeat (5) @(negedge clk);
		cap_adr.delete();
		cap_dat.delete();
		reset = 1'b0;
		wait_store(ok);
		if (!ok) begin
			errors++;
			$display("row %0d: no store seen before timeout", idx);
		end else begin
			wait_halt(ok);
			if (!ok) begin
				errors++;
				$display("row %0d: core never went quiet after the store", idx);
			end else begin
				check_word("adr", cap_adr[0], (r.kind == K_LDHL) ? HL2_ADR : HL_ADR);
				check_byte("dout", cap_dat[0], r.exp_byte);
				check_flags("f", f, r.exp_f);
				check_word("pc", pc, (r.exp_pc == 16'h0000) ? end_adr : r.exp_pc);
				if (cap_adr.size() != 1) begin
					errors++;
					$display("row %0d: expected one store, saw %0d", idx, cap_adr.size());
				end
				hold_pc = pc;
				moved = 1'b0;
				repeat (40) begin             // halt must hold
					@(negedge clk);
					if (read || write || pc !== hold_pc)
						moved = 1'b1;
				end
				if (moved) begin
					errors++;
					$display("row %0d: bus or pc moved while halted", idx);
				end
			end
		end
		$display("row %0d kind %0d op %h: %s", idx, r.kind, r.opc,
			(errors == err_start) ? "ok" : "mismatch");
	endtask

	initial begin
		int k;
		reset = 1'b1;
		din = 8'h00;
		seed_val = $urandom(32'h6bd6f600);
		// ALU, register form
		add_row(K_ALU, 2'd0, 8'h80, 8'h3a, 8'hc6, 8'h00, 8'h00, 0, 8'h00, 4'hb, 16'h0);
		add_row(K_ALU, 2'd0, 8'h88, 8'h0f, 8'h01, 8'h00, 8'h01, 0, 8'h11, 4'h2, 16'h0);
		add_row(K_ALU, 2'd0, 8'h90, 8'h3e, 8'h0f, 8'h00, 8'h00, 0, 8'h2f, 4'h6, 16'h0);
		add_row(K_ALU, 2'd0, 8'h98, 8'h10, 8'h0f, 8'h00, 8'h01, 0, 8'h00, 4'he, 16'h0);
		add_row(K_ALU, 2'd0, 8'ha0, 8'h5a, 8'h3c, 8'h00, 8'h00, 0, 8'h18, 4'h2, 16'h0);
		add_row(K_ALU, 2'd0, 8'ha8, 8'h5a, 8'h5a, 8'h00, 8'h00, 0, 8'h00, 4'h8, 16'h0);
		add_row(K_ALU, 2'd0, 8'hb0, 8'h50, 8'h0a, 8'h00, 8'h00, 0, 8'h5a, 4'h0, 16'h0);
		add_row(K_ALU, 2'd0, 8'hb8, 8'h10, 8'h20, 8'h00, 8'h00, 0, 8'h10, 4'h5, 16'h0);
		// d8 and (HL) operands
		add_row(K_ALU, 2'd1, 8'h80, 8'h3a, 8'hc6, 8'h00, 8'h00, 0, 8'h00, 4'hb, 16'h0);
		add_row(K_ALU, 2'd2, 8'h98, 8'h10, 8'h0f, 8'h00, 8'h01, 0, 8'h00, 4'he, 16'h0);
		add_row(K_ALU, 2'd1, 8'hb8, 8'h42, 8'h42, 8'h00, 8'h00, 0, 8'h42, 4'hc, 16'h0);
		add_row(K_ALU, 2'd2, 8'ha0, 8'hf0, 8'h0f, 8'h00, 8'h00, 0, 8'h00, 4'ha, 16'h0);
		// random operands
		add_row(K_ALU, 2'd0, 8'h88, 8'h00, 8'h00, 8'h00, 8'h01, 1, 8'h00, 4'h0, 16'h0);
		add_row(K_ALU, 2'd1, 8'h98, 8'h00, 8'h00, 8'h00, 8'h01, 1, 8'h00, 4'h0, 16'h0);
		add_row(K_ALU, 2'd2, 8'h90, 8'h00, 8'h00, 8'h00, 8'h00, 1, 8'h00, 4'h0, 16'h0);
		add_row(K_ALU, 2'd0, 8'hb8, 8'h00, 8'h00, 8'h00, 8'h00, 1, 8'h00, 4'h0, 16'h0);
		// INC and DEC on B and A, C carried from setup
		add_row(K_IDC, 2'd0, 8'h04, 8'hff, 8'h00, 8'h00, 8'h01, 0, 8'h00, 4'hb, 16'h0);
		add_row(K_IDC, 2'd0, 8'h05, 8'h00, 8'h00, 8'h00, 8'h00, 0, 8'hff, 4'h6, 16'h0);
		add_row(K_IDC, 2'd0, 8'h3c, 8'h0f, 8'h00, 8'h00, 8'h00, 0, 8'h10, 4'h2, 16'h0);
		add_row(K_IDC, 2'd0, 8'h3d, 8'h01, 8'h00, 8'h00, 8'h01, 0, 8'h00, 4'hd, 16'h0);
		// loads
		add_row(K_LDRR, 2'd0, 8'h51, 8'ha5, 8'h00, 8'h00, 8'h00, 0, 8'ha5, 4'hc, 16'h0);
		add_row(K_LDHL, 2'd0, 8'h7e, 8'h3c, 8'h00, 8'h00, 8'h01, 0, 8'h3c, 4'h7, 16'h0);
		// branches, flags 0/0 Z, 0/1 C, 5/1 neither
		add_row(K_JP, 2'd0, 8'hc3, 8'h00, 8'h00, 8'h00, 8'h00, 0, 8'h22, 4'hc, 16'h0024);
		add_row(K_JP, 2'd0, 8'hca, 8'h00, 8'h00, 8'h00, 8'h00, 0, 8'h22, 4'hc, 16'h0024);
		add_row(K_JP, 2'd0, 8'hc2, 8'h00, 8'h00, 8'h00, 8'h00, 0, 8'h11, 4'hc, 16'h000f);
		add_row(K_JP, 2'd0, 8'hda, 8'h00, 8'h00, 8'h00, 8'h01, 0, 8'h22, 4'h7, 16'h0024);
		add_row(K_JP, 2'd0, 8'hd2, 8'h00, 8'h00, 8'h00, 8'h01, 0, 8'h11, 4'h7, 16'h000f);
		add_row(K_JR, 2'd0, 8'h18, 8'h00, 8'h00, 8'h00, 8'h00, 0, 8'h22, 4'hc, 16'h0024);
		add_row(K_JR, 2'd0, 8'h20, 8'h00, 8'h00, 8'h05, 8'h01, 0, 8'h22, 4'h4, 16'h0024);
		add_row(K_JR, 2'd0, 8'h28, 8'h00, 8'h00, 8'h05, 8'h01, 0, 8'h11, 4'h4, 16'h000e);
		add_row(K_JRB, 2'd0, 8'h38, 8'h00, 8'h00, 8'h00, 8'h01, 0, 8'h22, 4'h7, 16'h0024);
		add_row(K_JRB, 2'd0, 8'h30, 8'h00, 8'h00, 8'h00, 8'h01, 0, 8'h11, 4'h7, 16'h0036);
		add_row(K_JRB, 2'd0, 8'h18, 8'h00, 8'h00, 8'h05, 8'h01, 0, 8'h22, 4'h4, 16'h0024);

		for (k = 0; k < table_q.size(); k++)
			run_row(table_q[k], k);

		$display("rows %0d, checks %0d, errors %0d", table_q.size(), checks, errors);
		if (errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+rtl
rtl/lr35902_pkg.sv
rtl/lr35902_alu.sv
rtl/lr35902_regfile.sv
rtl/lr35902_control.sv
rtl/lr35902_core.sv
test/lr35902_assertions.sv
test/lr35902_tb.sv

/* Bender.yml */
package:
  name: lr35902

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lr35902_pkg.sv
      - rtl/lr35902_alu.sv
      - rtl/lr35902_regfile.sv
      - rtl/lr35902_control.sv
      - rtl/lr35902_core.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/lr35902_assertions.sv
      - test/lr35902_tb.sv
